//--- ex.f
+incdir+.
ex_pkg.sv
ex_if.sv
alu_control.sv
ex_alu.sv
ex_execute.sv
ex_wb_frontend.sv
ex_result_stage.sv
ex_top.sv
ex_top_chk.sv
tb_ex_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ex_top
FILELIST  ?= ex.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ALL CHECKS PASSED

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST))) ex_defines.svh
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BINARY)
	@out="$$($(BINARY))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_ex_top.sv
`timescale 1ns/1ns
`include "ex_defines.svh"

module tb_ex_top import ex_pkg::*; ();

    localparam int ACK_TIMEOUT = 16;
    localparam fcode_t ALU_FCODES [9] = '{FC_ADD, FC_ADDU, FC_SUB, FC_SUBU, FC_AND,
                                          FC_OR, FC_XOR, FC_NOR, FC_SLT};
    localparam fcode_t SHIFT_FCODES [6] = '{FC_SLL, FC_SRL, FC_SRA, FC_SLLV, FC_SRLV, FC_SRAV};
    localparam opcode_t IMM_OPS [15] = '{OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
                                         OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWU,
                                         OP_SB, OP_SH, OP_SW};

    logic                     i_clk;
    logic                     i_reset;
    logic                     i_wb_cyc;
    logic                     i_wb_stb;
    logic                     i_wb_we;
    logic [`EX_NB_WB_ADR-1:0] i_wb_adr;
    logic [`EX_NB_DATA-1:0]   i_wb_dat;
    logic [`EX_NB_DATA-1:0]   o_wb_dat;
    logic                     o_wb_ack;
    logic [`EX_NB_COUNT-1:0]  exp_count;    // Completions seen so far

    ex_top dut0 (.i_clk(i_clk), .i_reset(i_reset), .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb),
                 .i_wb_we(i_wb_we), .i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat),
                 .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack));

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else abort_run($sformatf("Mismatch at %0t ns: %s got 0x%08h expected 0x%08h",
                                 $time, name, got, exp));
    endtask

    task automatic wait_ack();
        int cycles;
        cycles = 0;
        do begin
            @(negedge i_clk);
            cycles++;
        end while (!o_wb_ack && cycles < ACK_TIMEOUT);
        if (!o_wb_ack) abort_run("Timeout: the Wishbone slave never acknowledged");
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [31:0] dat);
        @(negedge i_clk);
        {i_wb_cyc, i_wb_stb, i_wb_we} = 3'b111;
        i_wb_adr = adr;
        i_wb_dat = dat;
        wait_ack();
        {i_wb_cyc, i_wb_stb, i_wb_we} = 3'b000;
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [31:0] dat);
        @(negedge i_clk);
        {i_wb_cyc, i_wb_stb, i_wb_we} = 3'b110;
        i_wb_adr = adr;
        wait_ack();
        dat = o_wb_dat;                     // Valid with ack
        {i_wb_cyc, i_wb_stb} = 2'b00;
    endtask

    function automatic logic [31:0] r_instr(input logic [5:0] fc, input logic [4:0] sa);
        return {6'h00, 15'($urandom), sa, fc};      // Register fields are noise
    endfunction

    function automatic logic [31:0] i_instr(input logic [5:0] op, input logic [15:0] imm);
        return {op, 10'($urandom), imm};
    endfunction

    function automatic logic [31:0] model_result(input logic [31:0] instr,
                                                 input logic [31:0] rs,
                                                 input logic [31:0] rt);
        logic [5:0]  op;
        logic [31:0] sx;
        logic [31:0] zx;
        logic [31:0] r;
        op = instr[31:26];
        sx = {{16{instr[15]}}, instr[15:0]};
        zx = {16'h0, instr[15:0]};
        case (op)
            OP_RTYPE: begin
                case (instr[5:0])
                    FC_SUB, FC_SUBU: r = rs - rt;
                    FC_AND:  r = rs & rt;
                    FC_OR:   r = rs | rt;
                    FC_XOR:  r = rs ^ rt;
                    FC_NOR:  r = ~(rs | rt);
                    FC_SLT:  r = {31'h0, $signed(rs) < $signed(rt)};
                    FC_SLL:  r = rt << instr[10:6];
                    FC_SRL:  r = rt >> instr[10:6];
                    FC_SRA:  r = $signed(rt) >>> instr[10:6];
                    FC_SLLV: r = rt << rs[4:0];
                    FC_SRLV: r = rt >> rs[4:0];
                    FC_SRAV: r = $signed(rt) >>> rs[4:0];
                    default: r = rs + rt;   // ADD, ADDU and unknown codes
                endcase
            end
            OP_BEQ:  r = rs - rt;
            OP_BNE:  r = {31'h0, rs != rt};
            OP_SLTI: r = {31'h0, $signed(rs) < $signed(sx)};
            OP_ANDI: r = rs & zx;
            OP_ORI:  r = rs | zx;
            OP_XORI: r = rs ^ zx;
            OP_LUI:  r = {instr[15:0], 16'h0};
            default: r = rs + sx;           // ADDI, loads, stores, unknown opcodes
        endcase
        return r;
    endfunction

    task automatic check_outputs(input logic [31:0] instr, input logic [31:0] exp_res);
        logic [31:0] got;
        logic        taken;
        taken = (instr[31:26] == OP_BEQ && exp_res == 32'h0) ||
                (instr[31:26] == OP_BNE && exp_res != 32'h0);
        wb_read(`EX_ADR_RESULT, got);
        check_value("RESULT", got, exp_res);
        wb_read(`EX_ADR_STATUS, got);
        check_value("STATUS", got, {16'h0, exp_count, 6'h0, taken, exp_res == 32'h0});
    endtask

    task automatic run_instr(input logic [31:0] instr, input logic [31:0] rs,
                             input logic [31:0] rt);
        wb_write(`EX_ADR_RS, rs);
        wb_write(`EX_ADR_RT, rt);
        wb_write(`EX_ADR_INSTR, instr);
        exp_count = exp_count + 1'b1;
        check_outputs(instr, model_result(instr, rs, rt));
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] rs_val;
        logic [31:0] instr2;
        int          k;
        i_reset = 1'b1;
        {i_wb_cyc, i_wb_stb, i_wb_we} = 3'b000;
        i_wb_adr = '0;
        i_wb_dat = '0;
        exp_count = '0;
        void'($urandom(51586));
        repeat (16) @(posedge i_clk);
        @(negedge i_clk);
        i_reset = 1'b0;

        for (k = 0; k < 8; k++) begin       // Mapped and unmapped addresses
            wb_read(3'(k), rd);
            check_value("register after reset", rd, 32'h0);
        end
        rs_val = $urandom;
        wb_write(`EX_ADR_RS, rs_val);
        wb_write(`EX_ADR_RT, ~rs_val);
        wb_write(`EX_ADR_RESULT, 32'hffff_ffff);
        wb_write(`EX_ADR_STATUS, 32'hffff_ffff);
        wb_read(`EX_ADR_RS, rd);
        check_value("RS", rd, rs_val);
        wb_read(`EX_ADR_RT, rd);
        check_value("RT", rd, ~rs_val);
        wb_read(`EX_ADR_RESULT, rd);        // Still the reset values
        check_value("RESULT", rd, 32'h0);
        wb_read(`EX_ADR_STATUS, rd);
        check_value("STATUS", rd, 32'h0);

        foreach (ALU_FCODES[i]) begin
            repeat (4) run_instr(r_instr(ALU_FCODES[i], 5'($urandom)), $urandom, $urandom);
        end
        run_instr(r_instr(FC_SLT, 5'd0), 32'hffff_fff0, 32'h5);
        run_instr(r_instr(FC_SLT, 5'd0), 32'h5, 32'hffff_fff0);

        foreach (SHIFT_FCODES[i]) begin
            repeat (3) run_instr(r_instr(SHIFT_FCODES[i], 5'($urandom)), $urandom, $urandom);
        end
        run_instr(r_instr(FC_SRA, 5'd13), $urandom, $urandom | 32'h8000_0000);
        run_instr(r_instr(FC_SRAV, 5'd0), 32'h7, $urandom | 32'h8000_0000);

        foreach (IMM_OPS[i]) begin
            run_instr(i_instr(IMM_OPS[i], 16'($urandom) & 16'h7fff), $urandom, $urandom);
            run_instr(i_instr(IMM_OPS[i], 16'($urandom) | 16'h8000), $urandom, $urandom);
        end

        rs_val = $urandom;
        run_instr(i_instr(OP_BEQ, 16'h0010), rs_val, rs_val);
        run_instr(i_instr(OP_BEQ, 16'h0010), rs_val, rs_val ^ 32'h1);
        run_instr(i_instr(OP_BNE, 16'hfff0), rs_val, rs_val);
        run_instr(i_instr(OP_BNE, 16'hfff0), rs_val, rs_val ^ 32'h8000_0000);

        wb_write(`EX_ADR_RS, rs_val);       // Two instructions in flight
        wb_write(`EX_ADR_RT, 32'h1234_5678);
        instr2 = r_instr(FC_XOR, 5'd0);
        wb_write(`EX_ADR_INSTR, r_instr(FC_ADD, 5'd0));
        wb_write(`EX_ADR_INSTR, instr2);
        exp_count = exp_count + 2'd2;
        check_outputs(instr2, model_result(instr2, rs_val, 32'h1234_5678));

        run_instr(i_instr(6'h3f, 16'($urandom)), $urandom, $urandom);
        run_instr(r_instr(6'h3f, 5'($urandom)), $urandom, $urandom);

        if (!dut0.u_chk.any_bad) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1, "Protocol assertion failed in the bound checker");
        end
    end

endmodule

//--- ex_top_chk.sv
`timescale 1ns/1ns
`include "ex_defines.svh"

module ex_top_chk (
    input logic                    i_clk,
    input logic                    i_reset,
    input logic                    i_wb_cyc,
    input logic                    i_wb_stb,
    input logic                    i_wb_ack,
    input logic                    i_issue_valid,
    input logic [`EX_NB_COUNT-1:0] i_count
);

    bit   ack_req_bad = 1'b0;
    bit   ack_len_bad = 1'b0;
    bit   reset_bad   = 1'b0;
    bit   step_bad    = 1'b0;
    bit   done_bad    = 1'b0;
    logic any_bad;

    assign any_bad = ack_req_bad | ack_len_bad | reset_bad | step_bad | done_bad;

    ack_follows_request: assert property (@(posedge i_clk) disable iff (i_reset)
        i_wb_ack |-> $past(i_wb_cyc && i_wb_stb))
    else begin
        $error("ack without cyc and stb in the previous cycle");
        ack_req_bad = 1'b1;
    end

    ack_single_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
        i_wb_ack |=> !i_wb_ack)
    else begin
        $error("ack held high for two cycles");
        ack_len_bad = 1'b1;
    end

    // Checked during reset as well
    quiet_after_reset: assert property (@(posedge i_clk)
        $past(i_reset) |-> (!i_wb_ack && !i_issue_valid))
    else begin
        $error("ack or issue valid high after a reset cycle");
        reset_bad = 1'b1;
    end

    count_single_step: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_count != $past(i_count)) |-> (i_count == $past(i_count) + 1'b1))
    else begin
        $error("completion count jumped by more than one");
        step_bad = 1'b1;
    end

    issue_completes: assert property (@(posedge i_clk) disable iff (i_reset)
        i_issue_valid |-> ##2 (i_count == $past(i_count) + 1'b1))
    else begin
        $error("issue not followed by a count increment two cycles later");
        done_bad = 1'b1;
    end

endmodule

bind ex_top ex_top_chk u_chk (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_wb_cyc      (i_wb_cyc),
    .i_wb_stb      (i_wb_stb),
    .i_wb_ack      (o_wb_ack),
    .i_issue_valid (issue_if.valid),
    .i_count       (count)
);

//--- ex_top.sv
`timescale 1ns/1ns
`include "ex_defines.svh"

module ex_top (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_wb_cyc,
    input  logic                    i_wb_stb,
    input  logic                    i_wb_we,
    input  logic [`EX_NB_WB_ADR-1:0] i_wb_adr,
    input  logic [`EX_NB_DATA-1:0]  i_wb_dat,
    output logic [`EX_NB_DATA-1:0]  o_wb_dat,
    output logic                    o_wb_ack
);

    logic [`EX_NB_DATA-1:0]  result;
    logic                    zero;
    logic                    branch_taken;
    logic [`EX_NB_COUNT-1:0] count;

    ex_issue_if  issue_if ();
    ex_result_if result_if ();

    ex_wb_frontend u_wb_frontend (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_wb_cyc       (i_wb_cyc),
        .i_wb_stb       (i_wb_stb),
        .i_wb_we        (i_wb_we),
        .i_wb_adr       (i_wb_adr),
        .i_wb_dat       (i_wb_dat),
        .o_wb_dat       (o_wb_dat),
        .o_wb_ack       (o_wb_ack),
        .issue          (issue_if.source),
        .i_result       (result),
        .i_zero         (zero),
        .i_branch_taken (branch_taken),
        .i_count        (count)
    );

    ex_execute u_execute (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .issue   (issue_if.sink),
        .res     (result_if.source)
    );

    ex_result_stage u_result_stage (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .res            (result_if.sink),
        .o_result       (result),
        .o_zero         (zero),
        .o_branch_taken (branch_taken),
        .o_count        (count)
    );

endmodule

//--- ex_result_stage.sv
`timescale 1ns/1ns
`include "ex_defines.svh"

module ex_result_stage (
    input  logic                    i_clk,
    input  logic                    i_reset,
    ex_result_if.sink               res,
    output logic [`EX_NB_DATA-1:0]  o_result,
    output logic                    o_zero,
    output logic                    o_branch_taken,
    output logic [`EX_NB_COUNT-1:0] o_count
);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_result       <= '0;
            o_zero         <= 1'b0;
            o_branch_taken <= 1'b0;
            o_count        <= '0;
        end else if (res.valid) begin
            o_result       <= res.result;
            o_zero         <= res.zero;
            o_branch_taken <= res.branch_taken;
            o_count        <= o_count + 1'b1;       // Wraps at 255
        end
    end

endmodule

//--- ex_wb_frontend.sv
`timescale 1ns/1ns
`include "ex_defines.svh"

module ex_wb_frontend (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_wb_cyc,
    input  logic                    i_wb_stb,
    input  logic                    i_wb_we,
    input  logic [`EX_NB_WB_ADR-1:0] i_wb_adr,
    input  logic [`EX_NB_DATA-1:0]  i_wb_dat,
    output logic [`EX_NB_DATA-1:0]  o_wb_dat,
    output logic                    o_wb_ack,
    ex_issue_if.source              issue,
    input  logic [`EX_NB_DATA-1:0]  i_result,
    input  logic                    i_zero,
    input  logic                    i_branch_taken,
    input  logic [`EX_NB_COUNT-1:0] i_count
);

    logic                   access;
    logic                   wr_en;
    logic [`EX_NB_DATA-1:0] rs_q;
    logic [`EX_NB_DATA-1:0] rt_q;
    logic [`EX_NB_DATA-1:0] instr_q;
    logic [`EX_NB_DATA-1:0] status;
    logic                   issue_q;

    assign access = i_wb_cyc & i_wb_stb & ~o_wb_ack;    // Ack drops after one cycle
    assign wr_en  = access & i_wb_we;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wb_ack <= 1'b0;
            issue_q  <= 1'b0;
            rs_q     <= '0;
            rt_q     <= '0;
            instr_q  <= '0;
        end else begin
            o_wb_ack <= access;
            issue_q  <= wr_en && (i_wb_adr == `EX_ADR_INSTR);
            if (wr_en) begin
                case (i_wb_adr)
                    `EX_ADR_RS:    rs_q    <= i_wb_dat;
                    `EX_ADR_RT:    rt_q    <= i_wb_dat;
                    `EX_ADR_INSTR: instr_q <= i_wb_dat;
                    default:       ;                    // RESULT and STATUS are read only
                endcase
            end
        end
    end

    assign issue.valid   = issue_q;
    assign issue.instr   = instr_q;
    assign issue.rs_data = rs_q;
    assign issue.rt_data = rt_q;

    always_comb begin
        status = '0;
        status[0] = i_zero;
        status[1] = i_branch_taken;
        status[8 +: `EX_NB_COUNT] = i_count;
    end

    always_comb begin
        case (i_wb_adr)
            `EX_ADR_RS:     o_wb_dat = rs_q;
            `EX_ADR_RT:     o_wb_dat = rt_q;
            `EX_ADR_INSTR:  o_wb_dat = instr_q;
            `EX_ADR_RESULT: o_wb_dat = i_result;
            `EX_ADR_STATUS: o_wb_dat = status;
            default:        o_wb_dat = '0;              // Unmapped
        endcase
    end

endmodule

//--- ex_execute.sv
`timescale 1ns/1ns
`include "ex_defines.svh"

module ex_execute import ex_pkg::*; (
    input  logic        i_clk,
    input  logic        i_reset,
    ex_issue_if.sink    issue,
    ex_result_if.source res
);

    localparam int NB_IMM = 16;

    alu_op_t                 alu_op;
    logic                    shamt_ctrl;
    logic [NB_IMM-1:0]       imm;
    logic [`EX_NB_SHAMT-1:0] shamt;
    logic [`EX_NB_DATA-1:0]  data_a;
    logic [`EX_NB_DATA-1:0]  data_b;
    logic [`EX_NB_DATA-1:0]  alu_result;
    logic                    taken;

    alu_control u_alu_control (
        .i_funct_code         (issue.funct),
        .i_instruction_opcode (issue.opcode),
        .o_alu_operation      (alu_op),
        .o_shamt_ctrl         (shamt_ctrl)
    );

    assign imm    = issue.instr[NB_IMM-1:0];
    assign shamt  = issue.instr[6 +: `EX_NB_SHAMT];
    assign data_a = shamt_ctrl ? {{(`EX_NB_DATA-`EX_NB_SHAMT){1'b0}}, shamt} : issue.rs_data;

    always_comb begin
        case (issue.opcode)
            OP_RTYPE, OP_BEQ, OP_BNE: data_b = issue.rt_data;
            OP_ANDI, OP_ORI, OP_XORI: data_b = {{(`EX_NB_DATA-NB_IMM){1'b0}}, imm};
            default:                  data_b = {{(`EX_NB_DATA-NB_IMM){imm[NB_IMM-1]}}, imm};
        endcase
    end

    ex_alu u_alu (
        .i_data_a (data_a),
        .i_data_b (data_b),
        .i_alu_op (alu_op),
        .o_result (alu_result)
    );

    assign taken = ((issue.opcode == OP_BEQ) && (alu_result == '0)) ||
                   ((issue.opcode == OP_BNE) && (alu_result != '0));

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            res.valid        <= 1'b0;
            res.result       <= '0;
            res.zero         <= 1'b0;
            res.branch_taken <= 1'b0;
        end else begin
            res.valid <= issue.valid;
            if (issue.valid) begin
                res.result       <= alu_result;
                res.zero         <= (alu_result == '0);
                res.branch_taken <= taken;
            end
        end
    end

endmodule

//--- ex_alu.sv
`timescale 1ns/1ns
`include "ex_defines.svh"

module ex_alu import ex_pkg::*; (
    input  logic [`EX_NB_DATA-1:0] i_data_a,
    input  logic [`EX_NB_DATA-1:0] i_data_b,
    input  alu_op_t                i_alu_op,
    output logic [`EX_NB_DATA-1:0] o_result
);

    localparam int NB_HALF = `EX_NB_DATA / 2;

    logic [`EX_NB_SHAMT-1:0] shift;

    assign shift = i_data_a[`EX_NB_SHAMT-1:0];     // Shift amount from A

    always_comb begin
        case (i_alu_op)
            ALU_ADD: o_result = i_data_a + i_data_b;
            ALU_SUB: o_result = i_data_a - i_data_b;
            ALU_AND: o_result = i_data_a & i_data_b;
            ALU_OR:  o_result = i_data_a | i_data_b;
            ALU_XOR: o_result = i_data_a ^ i_data_b;
            ALU_NOR: o_result = ~(i_data_a | i_data_b);
            ALU_SLT: begin
                o_result = {{(`EX_NB_DATA-1){1'b0}},
                            ($signed(i_data_a) < $signed(i_data_b))};
            end
            ALU_SLL: o_result = i_data_b << shift;
            ALU_SRL: o_result = i_data_b >> shift;
            ALU_SRA: o_result = $unsigned($signed(i_data_b) >>> shift);
            ALU_LUI: o_result = {i_data_b[NB_HALF-1:0], {NB_HALF{1'b0}}};
            ALU_BNE: begin
                o_result = {{(`EX_NB_DATA-1){1'b0}}, (i_data_a != i_data_b)};
            end
            default: o_result = i_data_a + i_data_b;
        endcase
    end

endmodule

//--- alu_control.sv
`timescale 1ns/1ns
`include "ex_defines.svh"

module alu_control import ex_pkg::*; (
    input  fcode_t  i_funct_code,           // Only meaningful for R-type
    input  opcode_t i_instruction_opcode,
    output alu_op_t o_alu_operation,
    output logic    o_shamt_ctrl            // Operand A from the shamt field
);

    always_comb begin
        o_alu_operation = ALU_ADD;          // Fallback for unknown codes
        o_shamt_ctrl    = 1'b0;

        case (i_instruction_opcode)
            OP_RTYPE: begin
                case (i_funct_code)
                    FC_ADD, FC_ADDU: begin
                        o_alu_operation = ALU_ADD;
                    end
                    FC_SUB, FC_SUBU: begin
                        o_alu_operation = ALU_SUB;
                    end
                    FC_AND: begin
                        o_alu_operation = ALU_AND;
                    end
                    FC_OR: begin
                        o_alu_operation = ALU_OR;
                    end
                    FC_XOR: begin
                        o_alu_operation = ALU_XOR;
                    end
                    FC_NOR: begin
                        o_alu_operation = ALU_NOR;
                    end
                    FC_SLT: begin
                        o_alu_operation = ALU_SLT;
                    end
                    FC_SLL: begin
                        o_alu_operation = ALU_SLL;
                        o_shamt_ctrl    = 1'b1;
                    end
                    FC_SRL: begin
                        o_alu_operation = ALU_SRL;
                        o_shamt_ctrl    = 1'b1;
                    end
                    FC_SRA: begin
                        o_alu_operation = ALU_SRA;
                        o_shamt_ctrl    = 1'b1;
                    end
                    FC_SLLV: o_alu_operation = ALU_SLL;     // Amount from rs
                    FC_SRLV: o_alu_operation = ALU_SRL;
                    FC_SRAV: o_alu_operation = ALU_SRA;
                    default: o_alu_operation = ALU_ADD;
                endcase
            end
            OP_ADDI: o_alu_operation = ALU_ADD;
            OP_BEQ:  o_alu_operation = ALU_SUB;             // Zero result means equal
            OP_BNE:  o_alu_operation = ALU_BNE;
            OP_ANDI: o_alu_operation = ALU_AND;
            OP_ORI:  o_alu_operation = ALU_OR;
            OP_XORI: o_alu_operation = ALU_XOR;
            OP_LUI:  o_alu_operation = ALU_LUI;
            OP_SLTI: o_alu_operation = ALU_SLT;
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWU: begin
                o_alu_operation = ALU_ADD;                  // Address only
            end
            OP_SB, OP_SH, OP_SW: begin
                o_alu_operation = ALU_ADD;
            end
            default: begin
                o_alu_operation = ALU_ADD;
                o_shamt_ctrl    = 1'b0;
            end
        endcase
    end

endmodule

//--- ex_if.sv
`timescale 1ns/1ns
`include "ex_defines.svh"

interface ex_issue_if import ex_pkg::*; ();
    logic                   valid;      // One-cycle start pulse
    logic [`EX_NB_DATA-1:0] instr;
    logic [`EX_NB_DATA-1:0] rs_data;
    logic [`EX_NB_DATA-1:0] rt_data;
    opcode_t                opcode;     // Decoded view of instr
    fcode_t                 funct;

    assign opcode = opcode_t'(instr[`EX_NB_DATA-1 -: `EX_NB_OPCODE]);
    assign funct  = fcode_t'(instr[`EX_NB_FCODE-1:0]);

    modport source (output valid, instr, rs_data, rt_data);
    modport sink (input valid, instr, rs_data, rt_data, opcode, funct);
endinterface

interface ex_result_if ();
    logic                   valid;
    logic [`EX_NB_DATA-1:0] result;
    logic                   zero;
    logic                   branch_taken;

    modport source (output valid, result, zero, branch_taken);
    modport sink (input valid, result, zero, branch_taken);
endinterface

//--- ex_pkg.sv
`include "ex_defines.svh"

package ex_pkg;

    typedef enum logic [`EX_NB_ALU_OP-1:0] {
        ALU_ADD = 4'd0,                     // Also the fallback operation
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI,
        ALU_BNE
    } alu_op_t;

    typedef enum logic [`EX_NB_OPCODE-1:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_SLTI  = 6'h0a,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_XORI  = 6'h0e,
        OP_LUI   = 6'h0f,
        OP_LB    = 6'h20,
        OP_LH    = 6'h21,
        OP_LW    = 6'h23,
        OP_LBU   = 6'h24,
        OP_LHU   = 6'h25,
        OP_LWU   = 6'h27,
        OP_SB    = 6'h28,
        OP_SH    = 6'h29,
        OP_SW    = 6'h2b
    } opcode_t;

    typedef enum logic [`EX_NB_FCODE-1:0] {
        FC_SLL  = 6'h00,
        FC_SRL  = 6'h02,
        FC_SRA  = 6'h03,
        FC_SLLV = 6'h04,
        FC_SRLV = 6'h06,
        FC_SRAV = 6'h07,
        FC_ADD  = 6'h20,
        FC_ADDU = 6'h21,
        FC_SUB  = 6'h22,
        FC_SUBU = 6'h23,
        FC_AND  = 6'h24,
        FC_OR   = 6'h25,
        FC_XOR  = 6'h26,
        FC_NOR  = 6'h27,
        FC_SLT  = 6'h2a
    } fcode_t;

endpackage

//--- ex_defines.svh
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// Datapath and decode field widths
`define EX_NB_DATA      32
`define EX_NB_OPCODE    6
`define EX_NB_FCODE     6
`define EX_NB_ALU_OP    4
`define EX_NB_SHAMT     5

// Host port
`define EX_NB_WB_ADR    3
`define EX_NB_COUNT     8

// Word addresses of the host-visible registers
`define EX_ADR_RS       3'd0
`define EX_ADR_RT       3'd1
`define EX_ADR_INSTR    3'd2
`define EX_ADR_RESULT   3'd3
`define EX_ADR_STATUS   3'd4

`endif
